//--- Makefile
TOP = l2_cache_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f sources.f

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f sources.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log

//--- l2_cache.sv
`timescale 1ns/1ps

module l2_cache
(
	input logic clk,
	input logic reset,

	input logic mem_read,
	input logic mem_write,
	input lc3b_types::lc3b_word mem_address,
	input lc3b_types::lc3b_c_block mem_wdata,
	output logic mem_resp,
	output lc3b_types::lc3b_c_block mem_rdata,

	input logic pmem_resp,
	input lc3b_types::lc3b_l2_block pmem_rdata,
	output logic pmem_read,
	output logic pmem_write,
	output lc3b_types::lc3b_word pmem_address,
	output lc3b_types::lc3b_l2_block pmem_wdata
);

logic hit;
logic tag1_valid;
logic tag2_valid;
logic lru_out;
logic dirty1_out;
logic dirty2_out;

logic ld_way1;
logic ld_way2;
logic ld_valid1;
logic ld_valid2;
logic ld_tag1;
logic ld_tag2;
logic ld_dirty1;
logic ld_dirty2;
logic ld_lru;

logic way1mux_sel;
logic way2mux_sel;
logic datamux_sel;
lc3b_types::l2_addr_sel addrmux_sel;

logic dirty1_in;
logic dirty2_in;

l2_cache_control control
(
	.clk, .reset,
	.mem_read, .mem_write, .pmem_resp,
	.hit, .tag1_valid, .tag2_valid, .lru_out, .dirty1_out, .dirty2_out,
	.mem_resp, .pmem_read, .pmem_write,
	.ld_way1, .ld_way2, .ld_valid1, .ld_valid2, .ld_tag1, .ld_tag2,
	.ld_dirty1, .ld_dirty2, .ld_lru,
	.way1mux_sel, .way2mux_sel, .datamux_sel, .addrmux_sel,
	.dirty1_in, .dirty2_in
);

l2_cache_datapath datapath
(
	.clk, .reset,
	.mem_address, .mem_wdata, .pmem_rdata,
	.dirty1_in, .dirty2_in,
	.ld_way1, .ld_way2, .ld_valid1, .ld_valid2, .ld_tag1, .ld_tag2,
	.ld_dirty1, .ld_dirty2, .ld_lru,
	.way1mux_sel, .way2mux_sel, .datamux_sel, .addrmux_sel,
	.hit, .lru_out, .dirty1_out, .dirty2_out, .tag1_valid, .tag2_valid,
	.pmem_address, .pmem_wdata, .mem_rdata
);

endmodule : l2_cache

//--- l2_cache_assert.sv
`timescale 1ns/1ps

module l2_cache_assert
(
	input logic clk,
	input logic reset,
	input logic mem_read,
	input logic mem_write,
	input logic mem_resp,
	input logic pmem_read,
	input logic pmem_write,
	input lc3b_types::lc3b_word pmem_address
);

strobes_exclusive: assert property (@(posedge clk) !(pmem_read && pmem_write))
	else $error("pmem_read and pmem_write are high together");

// memory side only ever sees whole lines
address_aligned: assert property (@(posedge clk)
	(pmem_read || pmem_write) |-> (pmem_address[4:0] == 5'b00000))
	else $error("pmem_address is not line aligned while a strobe is high");

resp_with_request: assert property (@(posedge clk) mem_resp |-> (mem_read || mem_write))
	else $error("mem_resp is high with no request present");

quiet_in_reset: assert property (@(posedge clk) reset |-> !(mem_resp || pmem_read || pmem_write))
	else $error("a strobe is high during reset");

endmodule : l2_cache_assert

bind l2_cache l2_cache_assert l2_cache_assert_inst
(
	.clk(clk), .reset(reset), .mem_read(mem_read), .mem_write(mem_write),
	.mem_resp(mem_resp), .pmem_read(pmem_read), .pmem_write(pmem_write),
	.pmem_address(pmem_address)
);

//--- l2_cache_control.sv
`timescale 1ns/1ps

module l2_cache_control
(
	input logic clk,
	input logic reset,

	input logic mem_read,
	input logic mem_write,
	input logic pmem_resp,

	input logic hit,
	input logic tag1_valid,
	input logic tag2_valid,
	input logic lru_out,
	input logic dirty1_out,
	input logic dirty2_out,

	output logic mem_resp,
	output logic pmem_read,
	output logic pmem_write,

	output logic ld_way1,
	output logic ld_way2,
	output logic ld_valid1,
	output logic ld_valid2,
	output logic ld_tag1,
	output logic ld_tag2,
	output logic ld_dirty1,
	output logic ld_dirty2,
	output logic ld_lru,

	output logic way1mux_sel,
	output logic way2mux_sel,
	output logic datamux_sel,
	output lc3b_types::l2_addr_sel addrmux_sel,

	output logic dirty1_in,
	output logic dirty2_in
);

typedef enum logic [1:0]
{
	check,
	write_back,
	allocate
} state_t;

state_t state;
state_t next_state;

logic request;
logic victim_dirty;

assign request = mem_read || mem_write;
assign victim_dirty = lru_out ? dirty2_out : dirty1_out;

always_comb
begin
	mem_resp = 1'b0;
	pmem_read = 1'b0;
	pmem_write = 1'b0;
	ld_way1 = 1'b0;
	ld_way2 = 1'b0;
	ld_valid1 = 1'b0;
	ld_valid2 = 1'b0;
	ld_tag1 = 1'b0;
	ld_tag2 = 1'b0;
	ld_dirty1 = 1'b0;
	ld_dirty2 = 1'b0;
	ld_lru = 1'b0;
	way1mux_sel = 1'b0;
	way2mux_sel = 1'b0;
	datamux_sel = 1'b0;
	addrmux_sel = lc3b_types::l2_addr_req;
	dirty1_in = 1'b0;
	dirty2_in = 1'b0;

	case (state)
		check:
		begin
			if (request && hit)
			begin
				mem_resp = 1'b1;
				datamux_sel = tag2_valid;
				ld_lru = 1'b1;
				// write hit stores merged line back into the hit way
				if (mem_write)
				begin
					if (tag1_valid)
					begin
						ld_way1 = 1'b1;
						ld_dirty1 = 1'b1;
						dirty1_in = 1'b1;
					end
					else
					begin
						ld_way2 = 1'b1;
						ld_dirty2 = 1'b1;
						dirty2_in = 1'b1;
					end
				end
			end
		end

		write_back:
		begin
			pmem_write = 1'b1;
			datamux_sel = lru_out;
			addrmux_sel = lru_out ? lc3b_types::l2_addr_way2 : lc3b_types::l2_addr_way1;
		end

		allocate:
		begin
			pmem_read = 1'b1;
			if (pmem_resp)
			begin
				if (lru_out)
				begin
					ld_way2 = 1'b1;
					way2mux_sel = 1'b1;
					ld_tag2 = 1'b1;
					ld_valid2 = 1'b1;
					ld_dirty2 = 1'b1;
				end
				else
				begin
					ld_way1 = 1'b1;
					way1mux_sel = 1'b1;
					ld_tag1 = 1'b1;
					ld_valid1 = 1'b1;
					ld_dirty1 = 1'b1;
				end
			end
		end

		default: ;
	endcase
end

always_comb
begin
	next_state = state;
	case (state)
		check:
		begin
			if (request && !hit)
				next_state = victim_dirty ? write_back : allocate;
		end

		write_back:
		begin
			if (pmem_resp)
				next_state = allocate;
		end

		allocate:
		begin
			// back in check the request hits on the fresh line
			if (pmem_resp)
				next_state = check;
		end

		default: next_state = check;
	endcase
end

always_ff @(posedge clk)
begin
	if (reset)
		state <= check;
	else
		state <= next_state;
end

endmodule : l2_cache_control

//--- l2_cache_datapath.sv
`timescale 1ns/1ps

module l2_cache_datapath
(
	input logic clk,
	input logic reset,
	input lc3b_types::lc3b_word mem_address,
	input lc3b_types::lc3b_c_block mem_wdata,
	input lc3b_types::lc3b_l2_block pmem_rdata,

	input logic dirty1_in,
	input logic dirty2_in,

	input logic ld_way1,
	input logic ld_way2,
	input logic ld_valid1,
	input logic ld_valid2,
	input logic ld_tag1,
	input logic ld_tag2,
	input logic ld_dirty1,
	input logic ld_dirty2,
	input logic ld_lru,

	input logic way1mux_sel,
	input logic way2mux_sel,
	input logic datamux_sel,
	input lc3b_types::l2_addr_sel addrmux_sel,

	output logic hit,
	output logic lru_out,
	output logic dirty1_out,
	output logic dirty2_out,
	output logic tag1_valid,
	output logic tag2_valid,

	output lc3b_types::lc3b_word pmem_address,
	output lc3b_types::lc3b_l2_block pmem_wdata,
	output lc3b_types::lc3b_c_block mem_rdata
);

logic valid1_out;
logic valid2_out;

lc3b_types::lc3b_l2_offset offset;
lc3b_types::lc3b_l2_line line;
lc3b_types::lc3b_l2_tag tag;
lc3b_types::lc3b_l2_tag tag1_out;
lc3b_types::lc3b_l2_tag tag2_out;

lc3b_types::lc3b_l2_block way1_in;
lc3b_types::lc3b_l2_block way2_in;
lc3b_types::lc3b_l2_block way1_out;
lc3b_types::lc3b_l2_block way2_out;
lc3b_types::lc3b_l2_block datamux_out;
lc3b_types::lc3b_l2_block update_out;

// low four bits address bytes inside an L1 block
assign offset = mem_address[4];
assign line = mem_address[7:5];
assign tag = mem_address[15:8];

// way inputs, merged line on write hit or fresh line on allocate
assign way1_in = way1mux_sel ? pmem_rdata : update_out;
assign way2_in = way2mux_sel ? pmem_rdata : update_out;

l2_line_array #(.payload_t(lc3b_types::lc3b_l2_block)) way1_array
(
	.clk, .reset, .write(ld_way1), .index(line), .datain(way1_in), .dataout(way1_out)
);

l2_line_array #(.payload_t(lc3b_types::lc3b_l2_block)) way2_array
(
	.clk, .reset, .write(ld_way2), .index(line), .datain(way2_in), .dataout(way2_out)
);

assign datamux_out = datamux_sel ? way2_out : way1_out;
assign pmem_wdata = datamux_out;
assign mem_rdata = offset ? datamux_out[255:128] : datamux_out[127:0];

l2_update_block update
(
	.in(datamux_out), .offset, .mem_wdata, .out(update_out)
);

l2_line_array #(.payload_t(logic)) valid1_array
(
	.clk, .reset, .write(ld_valid1), .index(line), .datain(1'b1), .dataout(valid1_out)
);

l2_line_array #(.payload_t(logic)) valid2_array
(
	.clk, .reset, .write(ld_valid2), .index(line), .datain(1'b1), .dataout(valid2_out)
);

l2_line_array #(.payload_t(logic)) dirty1_array
(
	.clk, .reset, .write(ld_dirty1), .index(line), .datain(dirty1_in), .dataout(dirty1_out)
);

l2_line_array #(.payload_t(logic)) dirty2_array
(
	.clk, .reset, .write(ld_dirty2), .index(line), .datain(dirty2_in), .dataout(dirty2_out)
);

l2_line_array #(.payload_t(lc3b_types::lc3b_l2_tag)) tag1_array
(
	.clk, .reset, .write(ld_tag1), .index(line), .datain(tag), .dataout(tag1_out)
);

l2_line_array #(.payload_t(lc3b_types::lc3b_l2_tag)) tag2_array
(
	.clk, .reset, .write(ld_tag2), .index(line), .datain(tag), .dataout(tag2_out)
);

// a hit in way 1 makes way 2 the next victim and vice versa
l2_line_array #(.payload_t(logic)) lru_array
(
	.clk, .reset, .write(ld_lru), .index(line), .datain(tag1_valid), .dataout(lru_out)
);

// physical address, always line aligned
always_comb
begin
	case (addrmux_sel)
		lc3b_types::l2_addr_way1: pmem_address = {tag1_out, line, 5'b00000};
		lc3b_types::l2_addr_way2: pmem_address = {tag2_out, line, 5'b00000};
		default: pmem_address = {mem_address[15:5], 5'b00000};
	endcase
end

assign tag1_valid = valid1_out && (tag1_out == tag);
assign tag2_valid = valid2_out && (tag2_out == tag);
assign hit = tag1_valid || tag2_valid;

endmodule : l2_cache_datapath

//--- l2_cache_golden.txt
// columns: op (0 read, 1 write), address, write block, expected read block,
// expected memory reads so far, expected memory writes so far (all hex)
0 1020 00000000000000000000000000000000 102e102c102a10281026102410221020 01 00
0 1030 00000000000000000000000000000000 103e103c103a10381036103410321030 01 00
0 1020 00000000000000000000000000000000 102e102c102a10281026102410221020 01 00
1 1030 0123456789abcdeffedcba9876543210 00000000000000000000000000000000 01 00
0 1030 00000000000000000000000000000000 0123456789abcdeffedcba9876543210 01 00
0 1020 00000000000000000000000000000000 102e102c102a10281026102410221020 01 00
0 2020 00000000000000000000000000000000 202e202c202a20282026202420222020 02 00
0 3020 00000000000000000000000000000000 302e302c302a30283026302430223020 03 01
0 1030 00000000000000000000000000000000 0123456789abcdeffedcba9876543210 04 01
0 1020 00000000000000000000000000000000 102e102c102a10281026102410221020 04 01
0 2030 00000000000000000000000000000000 203e203c203a20382036203420322030 05 01
1 4040 deadbeefcafef00d0badc0de12345678 00000000000000000000000000000000 06 01
0 4040 00000000000000000000000000000000 deadbeefcafef00d0badc0de12345678 06 01
0 4050 00000000000000000000000000000000 405e405c405a40584056405440524050 06 01
1 2030 11112222333344445555666677778888 00000000000000000000000000000000 06 01
0 5020 00000000000000000000000000000000 502e502c502a50285026502450225020 07 01
0 6030 00000000000000000000000000000000 603e603c603a60386036603460326030 08 02
0 2030 00000000000000000000000000000000 11112222333344445555666677778888 09 02
0 2020 00000000000000000000000000000000 202e202c202a20282026202420222020 09 02
0 0000 00000000000000000000000000000000 000e000c000a00080006000400020000 0a 02
0 ffe0 00000000000000000000000000000000 ffeeffecffeaffe8ffe6ffe4ffe2ffe0 0b 02
1 fff0 0f1e2d3c4b5a69788796a5b4c3d2e1f0 00000000000000000000000000000000 0b 02
0 fff0 00000000000000000000000000000000 0f1e2d3c4b5a69788796a5b4c3d2e1f0 0b 02

//--- l2_cache_tb.sv
`timescale 1ns/1ps

module l2_cache_tb;

localparam int num_records = 23;
localparam int record_words = 6;
localparam int response_timeout = 64;

logic clk;
logic reset;
logic mem_read;
logic mem_write;
lc3b_types::lc3b_word mem_address;
lc3b_types::lc3b_c_block mem_wdata;
logic mem_resp;
lc3b_types::lc3b_c_block mem_rdata;
logic pmem_resp;
lc3b_types::lc3b_l2_block pmem_rdata;
logic pmem_read;
logic pmem_write;
lc3b_types::lc3b_word pmem_address;
lc3b_types::lc3b_l2_block pmem_wdata;

// six entries per request, in file column order
logic [127:0] golden [num_records * record_words];
lc3b_types::lc3b_l2_block memory [2048];
int read_count;
int write_count;

l2_cache l2_cache_inst
(
	.clk, .reset,
	.mem_read, .mem_write, .mem_address, .mem_wdata, .mem_resp, .mem_rdata,
	.pmem_resp, .pmem_rdata, .pmem_read, .pmem_write, .pmem_address, .pmem_wdata
);

initial
begin
	clk = 1'b0;
	forever #50 clk = ~clk;
end

task automatic fail_run();
	$display("Finished with errors");
	$fatal(1, "run stopped at the first error");
endtask

task automatic check_value(input logic [255:0] actual, input logic [255:0] expected,
	input string what);
	if (actual !== expected)
	begin
		$display("Mismatch at %0t: %s, got %h, expected %h", $time, what, actual, expected);
		fail_run();
	end
endtask

// every word holds the low 16 bits of its own byte address
task automatic fill_memory();
	for (int l = 0; l < 2048; l++)
	begin
		for (int w = 0; w < 16; w++)
			memory[l][w * 16 +: 16] = 16'(l * 32 + w * 2);
	end
endtask

task automatic serve_memory_access();
	logic [10:0] line_index;
	line_index = pmem_address[15:5];
	if (pmem_write)
	begin
		memory[line_index] = pmem_wdata;
		write_count++;
	end
	else
	begin
		pmem_rdata = memory[line_index];
		read_count++;
	end
	pmem_resp = 1'b1;
endtask

task automatic wait_for_response(input int r, output lc3b_types::lc3b_c_block data);
	int cycles;
	cycles = 0;
	@(negedge clk);
	while (!mem_resp && cycles < response_timeout)
	begin
		@(negedge clk);
		cycles++;
	end
	if (!mem_resp)
	begin
		$display("Error: no response from cache for request %0d after %0d cycles", r, cycles);
		fail_run();
	end
	else
		data = mem_rdata;
endtask

task automatic run_request(input int r);
	int base;
	logic op;
	lc3b_types::lc3b_c_block rdata_expected;
	lc3b_types::lc3b_c_block rdata_seen;
	base = r * record_words;
	op = golden[base][0];
	rdata_expected = golden[base + 3];
	@(posedge clk);
	#5;
	mem_address = golden[base + 1][15:0];
	mem_wdata = golden[base + 2];
	mem_read = !op;
	mem_write = op;
	wait_for_response(r, rdata_seen);
	@(posedge clk);
	#5;
	mem_read = 1'b0;
	mem_write = 1'b0;
	if (!op)
		check_value(256'(rdata_seen), 256'(rdata_expected),
			$sformatf("read data of request %0d at %h", r, mem_address));
	check_value(256'(read_count), 256'(golden[base + 4]),
		$sformatf("memory reads after request %0d", r));
	check_value(256'(write_count), 256'(golden[base + 5]),
		$sformatf("memory writes after request %0d", r));
endtask

// physical memory with a random response delay per access
initial
begin : memory_model
	int delay;
	void'($urandom(32'h820d));
	pmem_resp = 1'b0;
	pmem_rdata = '0;
	read_count = 0;
	write_count = 0;
	fill_memory();
	forever
	begin
		@(negedge clk);
		if (!reset && (pmem_read || pmem_write))
		begin
			delay = $urandom_range(4, 1);
			repeat (delay) @(posedge clk);
			#5;
			serve_memory_access();
			@(posedge clk);
			#5;
			pmem_resp = 1'b0;
		end
	end
end

initial
begin
	reset = 1'b1;
	mem_read = 1'b0;
	mem_write = 1'b0;
	mem_address = '0;
	mem_wdata = '0;
	$readmemh("l2_cache_golden.txt", golden);

	repeat (3) @(posedge clk);
	@(negedge clk);
	check_value(256'({mem_resp, pmem_read, pmem_write}), '0, "strobes during reset");
	@(posedge clk);
	#5;
	reset = 1'b0;
	@(negedge clk);
	check_value(256'({mem_resp, pmem_read, pmem_write}), '0, "strobes after reset");

	for (int r = 0; r < num_records; r++)
		run_request(r);

	$display("Finished with no errors");
	$finish;
end

endmodule : l2_cache_tb

//--- l2_line_array.sv
`timescale 1ns/1ps

module l2_line_array
#(
	parameter type payload_t = logic
)
(
	input logic clk,
	input logic reset,
	input logic write,
	input lc3b_types::lc3b_l2_line index,
	input payload_t datain,
	output payload_t dataout
);

localparam int num_sets = 2 ** $bits(lc3b_types::lc3b_l2_line);

payload_t data [num_sets];

always_ff @(posedge clk)
begin
	if (reset)
	begin
		for (int i = 0; i < num_sets; i++)
			data[i] <= '0;
	end
	else if (write)
	begin
		data[index] <= datain;
	end
end

// read is combinational
assign dataout = data[index];

endmodule : l2_line_array

//--- l2_update_block.sv
`timescale 1ns/1ps

module l2_update_block
(
	input lc3b_types::lc3b_l2_block in,
	input lc3b_types::lc3b_l2_offset offset,
	input lc3b_types::lc3b_c_block mem_wdata,
	output lc3b_types::lc3b_l2_block out
);

// whole half is replaced, no byte enables
always_comb
begin
	if (offset)
	begin
		out = {mem_wdata, in[127:0]};
	end
	else
	begin
		out = {in[255:128], mem_wdata};
	end
end

endmodule : l2_update_block

//--- lc3b_types.sv
package lc3b_types;

	// 16-bit address or data word
	typedef logic [15:0] lc3b_word;

	// block exchanged with the L1 cache
	typedef logic [127:0] lc3b_c_block;

	// full line exchanged with physical memory
	typedef logic [255:0] lc3b_l2_block;

	// selects lower or upper half of a line
	typedef logic lc3b_l2_offset;

	// set index, 8 sets
	typedef logic [2:0] lc3b_l2_line;

	typedef logic [7:0] lc3b_l2_tag;

	// physical address source
	typedef enum logic [1:0]
	{
		l2_addr_req  = 2'b00,
		l2_addr_way1 = 2'b01,
		l2_addr_way2 = 2'b10
	} l2_addr_sel;

endpackage : lc3b_types

//--- sources.f
lc3b_types.sv
l2_line_array.sv
l2_update_block.sv
l2_cache_datapath.sv
l2_cache_control.sv
l2_cache.sv
l2_cache_assert.sv
l2_cache_tb.sv
